/* hdl/cart_loader_pkg.sv */
package cart_loader_pkg;

	//////////////////////////////
	// Bus widths
	//////////////////////////////
	parameter int ADDR_W    = 25;
	parameter int DATA_W    = 16;
	parameter int INDEX_W   = 8;
	parameter int GG_CODE_W = 129; // Strobe, flags, address, compare, replace

	// Code downloads come in on the last index
	parameter logic [INDEX_W-1:0] CODE_INDEX = '1;

	//////////////////////////////
	// Cartridge header map
	//////////////////////////////
	parameter logic [ADDR_W-1:0] HDR_REGION_ADDR   = 25'h1F0; // Region chars 1 and 2
	parameter logic [ADDR_W-1:0] HDR_REGION2_ADDR  = 25'h1F2; // Region char 3
	parameter logic [ADDR_W-1:0] HDR_END_ADDR      = 25'h200;
	parameter logic [ADDR_W-1:0] SERIAL_FIRST_ADDR = 25'h182;
	parameter logic [ADDR_W-1:0] SERIAL_MATCH_ADDR = 25'h18C;

	// Light-gun timing when the serial is unknown
	parameter logic [7:0] DEFAULT_GUN_DELAY = 8'd44;

	// Encoding shared with the console core
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	// Search order used when several header flags are set
	typedef enum logic [1:0] {
		PRIO_US_EU_JP = 2'd0,
		PRIO_EU_US_JP = 2'd1,
		PRIO_US_JP_EU = 2'd2,
		PRIO_JP_US_EU = 2'd3
	} region_prio_e;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic fifo;
		logic noram;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} cart_quirks_t;

endpackage

/* hdl/ioctl_if.sv */
`timescale 1ns/1ps

// Registered host download bus
interface ioctl_if #(
	parameter int ADDR_W = 25,
	parameter int DATA_W = 16
);
	logic                                 cart_wr;     // One-cycle strobe
	logic                                 code_wr;     // One-cycle strobe
	logic [ADDR_W-1:0]                    addr;
	logic [DATA_W-1:0]                    data;
	logic [cart_loader_pkg::INDEX_W-1:0] index;
	logic                                 cart_active;
	logic                                 cart_start;  // Rise of cart_active
	logic                                 cart_end;    // Fall of cart_active

	modport src (
		output cart_wr, code_wr, addr, data, index,
		output cart_active, cart_start, cart_end
	);
	modport snk (
		input cart_wr, code_wr, addr, data, index,
		input cart_active, cart_start, cart_end
	);
endinterface

// Region flags found in the cartridge header
interface cart_hdr_if;
	logic hdr_j;
	logic hdr_u;
	logic hdr_e;
	logic hdr_ready;

	modport src (output hdr_j, hdr_u, hdr_e, hdr_ready);
	modport snk (input hdr_j, hdr_u, hdr_e, hdr_ready);
endinterface

/* hdl/download_decoder.sv */
`timescale 1ns/1ps

module download_decoder #(
	parameter int ADDR_W = 25,
	parameter int DATA_W = 16
) (
	input  logic                                 clk_sys,
	input  logic                                 RESET,
	input  logic                                 ioctl_download,
	input  logic [cart_loader_pkg::INDEX_W-1:0] ioctl_index,
	input  logic                                 ioctl_wr,
	input  logic [ADDR_W-1:0]                    ioctl_addr,
	input  logic [DATA_W-1:0]                    ioctl_data,
	ioctl_if.src                                 bus
);

	logic code_sel;
	logic cart_next;

	assign code_sel  = (ioctl_index == cart_loader_pkg::CODE_INDEX);
	assign cart_next = ioctl_download & ~code_sel;

	// Strobes and download state
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bus.cart_wr     <= 1'b0;
			bus.code_wr     <= 1'b0;
			bus.cart_active <= 1'b0;
			bus.cart_start  <= 1'b0;
			bus.cart_end    <= 1'b0;
		end else begin
			bus.cart_wr     <= cart_next & ioctl_wr;
			bus.code_wr     <= ioctl_download & code_sel & ioctl_wr;
			bus.cart_active <= cart_next;
			bus.cart_start  <= cart_next & ~bus.cart_active; // Edges against last cycle
			bus.cart_end    <= ~cart_next & bus.cart_active;
		end
	end

	// Payload, valid with the strobes
	always_ff @(posedge clk_sys) begin
		bus.addr  <= ioctl_addr;
		bus.data  <= ioctl_data;
		bus.index <= ioctl_index;
	end

endmodule

/* hdl/header_scanner.sv */
`timescale 1ns/1ps

module header_scanner #(
	parameter int ADDR_W = 25,
	parameter int DATA_W = 16
) (
	input  logic                          clk_sys,
	input  logic                          RESET,
	ioctl_if.snk                          bus,
	cart_hdr_if.src                       hdr,
	output cart_loader_pkg::cart_quirks_t quirks,
	output logic                          gun_type,
	output logic [7:0]                    gun_sensor_delay
);

	logic [7:0]  lo;
	logic [7:0]  hi;
	logic [3:0]  hrgn;
	logic        wr_rgn;
	logic        wr_rgn2;
	logic        wr_end;
	logic        wr_match;
	logic [2:0]  flags;     // {j, u, e}
	logic [2:0]  flags_nxt;
	logic        ready;
	logic [63:0] cart_id;   // 8 ASCII chars, first char on top

	cart_loader_pkg::cart_quirks_t id_quirks;
	logic                          id_gun_type;
	logic [7:0]                    id_gun_delay;

	assign lo   = bus.data[7:0];
	assign hi   = bus.data[DATA_W-1 -: 8];
	assign hrgn = lo[3:0] - 4'd7; // 'A'..'F' to 10..15

	assign wr_rgn   = bus.cart_wr && (bus.addr == ADDR_W'(cart_loader_pkg::HDR_REGION_ADDR));
	assign wr_rgn2  = bus.cart_wr && (bus.addr == ADDR_W'(cart_loader_pkg::HDR_REGION2_ADDR));
	assign wr_end   = bus.cart_wr && (bus.addr == ADDR_W'(cart_loader_pkg::HDR_END_ADDR));
	assign wr_match = bus.cart_wr && (bus.addr == ADDR_W'(cart_loader_pkg::SERIAL_MATCH_ADDR));

	function automatic logic [2:0] jue_of(input logic [7:0] c);
		return {c == "J", c == "U", c == "E"};
	endfunction

	//////////////////////////////
	// Region letters
	//////////////////////////////
	always_comb begin
		flags_nxt = flags;
		if (wr_rgn) begin
			if (|jue_of(lo))
				flags_nxt = flags_nxt | jue_of(lo);
			else if (lo >= "0" && lo <= "9")
				flags_nxt = {lo[0], lo[2], lo[3]}; // Bit mask form
			else if (lo >= "A" && lo <= "F")
				flags_nxt = {hrgn[0], hrgn[2], hrgn[3]};
			flags_nxt = flags_nxt | jue_of(hi); // Second char only as letter
		end
		if (wr_rgn2)
			flags_nxt = flags_nxt | jue_of(lo);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			flags <= 3'b000;
			ready <= 1'b0;
		end else begin
			flags <= bus.cart_start ? 3'b000 : flags_nxt;
			if (bus.cart_end)
				ready <= 1'b0;
			else if (wr_end)
				ready <= 1'b1;
		end
	end

	assign hdr.hdr_j     = flags[2];
	assign hdr.hdr_u     = flags[1];
	assign hdr.hdr_e     = flags[0];
	assign hdr.hdr_ready = ready;

	//////////////////////////////
	// Serial and quirk table
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (bus.cart_wr) begin
			case (bus.addr)
				ADDR_W'(cart_loader_pkg::SERIAL_FIRST_ADDR):      cart_id[63:56] <= hi;
				ADDR_W'(cart_loader_pkg::SERIAL_FIRST_ADDR + 2):  cart_id[55:40] <= {lo, hi};
				ADDR_W'(cart_loader_pkg::SERIAL_FIRST_ADDR + 4):  cart_id[39:24] <= {lo, hi};
				ADDR_W'(cart_loader_pkg::SERIAL_FIRST_ADDR + 6):  cart_id[23:8]  <= {lo, hi};
				ADDR_W'(cart_loader_pkg::SERIAL_FIRST_ADDR + 8):  cart_id[7:0]   <= lo;
				default: ;
			endcase
		end
	end

	always_comb begin
		id_quirks    = '0;
		id_gun_type  = 1'b0;
		id_gun_delay = cart_loader_pkg::DEFAULT_GUN_DELAY;
		case (cart_id)
			"T-081276": id_quirks.sram   = 1'b1;
			"MK-1215 ": id_quirks.eeprom = 1'b1;
			"T-113016": id_quirks.noram  = 1'b1; // Fake RAM check
			"T-89016 ": id_quirks.fifo   = 1'b1;
			"T-574023": id_quirks.pier   = 1'b1;
			"MK-1229 ": id_quirks.svp    = 1'b1;
			"T-35036 ": id_quirks.fmbusy = 1'b1;
			"T-68???-": id_quirks.schan  = 1'b1;
			"MK-1533 ": id_gun_delay     = 8'd100;
			"T-95096-": begin
				id_gun_type  = 1'b1; // Konami gun
				id_gun_delay = 8'd52;
			end
			"T-081156": id_gun_delay     = 8'd126;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			quirks           <= '0;
			gun_type         <= 1'b0;
			gun_sensor_delay <= cart_loader_pkg::DEFAULT_GUN_DELAY;
		end else if (bus.cart_start) begin
			quirks <= '0;
		end else if (wr_match) begin
			quirks           <= quirks | id_quirks;
			gun_type         <= id_gun_type;
			gun_sensor_delay <= id_gun_delay;
		end
	end

endmodule

/* hdl/region_select.sv */
`timescale 1ns/1ps

module region_select (
	input  logic                          clk_sys,
	input  logic                          RESET,
	ioctl_if.snk                          bus,
	cart_hdr_if.snk                       hdr,
	input  logic                          auto_region_en,
	input  logic                          region_from_header,
	input  cart_loader_pkg::region_prio_e region_prio,
	output cart_loader_pkg::region_e      region_req,
	output logic                          region_set
);

	logic old_ready;
	logic ready_rise;
	logic ready_fall;

	assign ready_rise = hdr.hdr_ready & ~old_ready;
	assign ready_fall = ~hdr.hdr_ready & old_ready;

	// First flagged region in priority order, else the order's head
	function automatic cart_loader_pkg::region_e pick_region(
		input cart_loader_pkg::region_prio_e prio,
		input logic j,
		input logic u,
		input logic e
	);
		cart_loader_pkg::region_e r;
		case (prio)
			cart_loader_pkg::PRIO_US_EU_JP:
				r = u ? cart_loader_pkg::REGION_US : e ? cart_loader_pkg::REGION_EU :
				    j ? cart_loader_pkg::REGION_JP : cart_loader_pkg::REGION_US;
			cart_loader_pkg::PRIO_EU_US_JP:
				r = e ? cart_loader_pkg::REGION_EU : u ? cart_loader_pkg::REGION_US :
				    j ? cart_loader_pkg::REGION_JP : cart_loader_pkg::REGION_EU;
			cart_loader_pkg::PRIO_US_JP_EU:
				r = u ? cart_loader_pkg::REGION_US : j ? cart_loader_pkg::REGION_JP :
				    e ? cart_loader_pkg::REGION_EU : cart_loader_pkg::REGION_US;
			default:
				r = j ? cart_loader_pkg::REGION_JP : u ? cart_loader_pkg::REGION_US :
				    e ? cart_loader_pkg::REGION_EU : cart_loader_pkg::REGION_JP;
		endcase
		return r;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_ready  <= 1'b0;
			region_req <= cart_loader_pkg::REGION_JP;
			region_set <= 1'b0;
		end else begin
			old_ready <= hdr.hdr_ready;
			if (ready_rise && auto_region_en) begin
				if (region_from_header) begin
					region_set <= 1'b1;
					region_req <= pick_region(region_prio, hdr.hdr_j, hdr.hdr_u, hdr.hdr_e);
				end else begin
					region_set <= |bus.index; // Index 0 keeps the menu choice
					region_req <= cart_loader_pkg::region_e'(bus.index[7:6]);
				end
			end
			if (ready_fall)
				region_set <= 1'b0;
		end
	end

endmodule

/* hdl/rom_write_sequencer.sv */
`timescale 1ns/1ps

module rom_write_sequencer #(
	parameter int ADDR_W = 25,
	parameter int DATA_W = 16
) (
	input  logic              clk_sys,
	input  logic              RESET,
	ioctl_if.snk              bus,
	input  logic              rom_wr_ack,
	output logic              ioctl_wait,
	output logic              rom_wr_req,
	output logic [ADDR_W-2:0] rom_addr,
	output logic [DATA_W-1:0] rom_wdata,
	output logic [ADDR_W-1:0] rom_size
);

	localparam int HALF_W = DATA_W / 2;

	//////////////////////////////
	// Toggle handshake
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ioctl_wait <= 1'b0;
			rom_wr_req <= 1'b0;
		end else if (bus.cart_wr) begin
			ioctl_wait <= 1'b1;
			rom_wr_req <= ~rom_wr_req; // New request
		end else if (ioctl_wait && (rom_wr_req == rom_wr_ack)) begin
			ioctl_wait <= 1'b0;
		end
	end

	// Word address and big-endian data for the memory
	always_ff @(posedge clk_sys) begin
		if (bus.cart_wr) begin
			rom_addr  <= bus.addr[ADDR_W-1:1];
			rom_wdata <= {bus.data[HALF_W-1:0], bus.data[DATA_W-1:HALF_W]};
		end
		if (bus.cart_end)
			rom_size <= bus.addr; // Last address of the image
	end

endmodule

/* hdl/cheat_code_loader.sv */
`timescale 1ns/1ps

module cheat_code_loader #(
	parameter int ADDR_W = 25,
	parameter int DATA_W = 16
) (
	input  logic                                   clk_sys,
	input  logic                                   RESET,
	ioctl_if.snk                                   bus,
	output logic [cart_loader_pkg::GG_CODE_W-1:0] gg_code,
	output logic                                   gg_reset
);

	logic [cart_loader_pkg::GG_CODE_W-2:0] fields; // Flags, address, compare, replace
	logic                                   code_stb;

	// Each 32-bit field arrives low half first
	always_ff @(posedge clk_sys) begin
		if (bus.code_wr) begin
			case (bus.addr[3:0])
				4'd0:  fields[96 +: DATA_W]  <= bus.data;
				4'd2:  fields[112 +: DATA_W] <= bus.data;
				4'd4:  fields[64 +: DATA_W]  <= bus.data;
				4'd6:  fields[80 +: DATA_W]  <= bus.data;
				4'd8:  fields[32 +: DATA_W]  <= bus.data;
				4'd10: fields[48 +: DATA_W]  <= bus.data;
				4'd12: fields[0 +: DATA_W]   <= bus.data;
				4'd14: fields[16 +: DATA_W]  <= bus.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_stb <= 1'b0;
			gg_reset <= 1'b0;
		end else begin
			code_stb <= bus.code_wr && (bus.addr[3:0] == 4'd14); // Last half closes the code
			gg_reset <= bus.code_wr && (bus.addr == {ADDR_W{1'b0}});
		end
	end

	assign gg_code = {code_stb, fields};

endmodule

/* hdl/cart_loader.sv */
`timescale 1ns/1ps

module cart_loader #(
	parameter int ADDR_W = cart_loader_pkg::ADDR_W,
	parameter int DATA_W = cart_loader_pkg::DATA_W
) (
	input  logic                                   clk_sys,
	input  logic                                   RESET,
	// Host download
	input  logic                                   ioctl_download,
	input  logic [cart_loader_pkg::INDEX_W-1:0]   ioctl_index,
	input  logic                                   ioctl_wr,
	input  logic [ADDR_W-1:0]                      ioctl_addr,
	input  logic [DATA_W-1:0]                      ioctl_data,
	output logic                                   ioctl_wait,
	// ROM memory
	output logic                                   rom_wr_req,
	input  logic                                   rom_wr_ack,
	output logic [ADDR_W-2:0]                      rom_addr,
	output logic [DATA_W-1:0]                      rom_wdata,
	output logic [ADDR_W-1:0]                      rom_size,
	// Region control
	input  logic                                   auto_region_en,
	input  logic                                   region_from_header,
	input  cart_loader_pkg::region_prio_e          region_prio,
	output cart_loader_pkg::region_e               region_req,
	output logic                                   region_set,
	// Cartridge specials
	output cart_loader_pkg::cart_quirks_t          quirks,
	output logic                                   gun_type,
	output logic [7:0]                             gun_sensor_delay,
	output logic [cart_loader_pkg::GG_CODE_W-1:0] gg_code,
	output logic                                   gg_reset
);

	ioctl_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) dl_bus ();
	cart_hdr_if hdr_bus ();

	download_decoder #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_decoder (
		.clk_sys, .RESET,
		.ioctl_download, .ioctl_index, .ioctl_wr, .ioctl_addr, .ioctl_data,
		.bus (dl_bus)
	);

	header_scanner #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_header (
		.clk_sys, .RESET,
		.bus (dl_bus),
		.hdr (hdr_bus),
		.quirks, .gun_type, .gun_sensor_delay
	);

	region_select i_region (
		.clk_sys, .RESET,
		.bus (dl_bus),
		.hdr (hdr_bus),
		.auto_region_en, .region_from_header, .region_prio,
		.region_req, .region_set
	);

	rom_write_sequencer #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_rom_seq (
		.clk_sys, .RESET,
		.bus (dl_bus),
		.rom_wr_ack, .ioctl_wait, .rom_wr_req, .rom_addr, .rom_wdata, .rom_size
	);

	cheat_code_loader #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_cheat (
		.clk_sys, .RESET,
		.bus (dl_bus),
		.gg_code, .gg_reset
	);

endmodule

/* dv/clk_gen.sv */
`timescale 1ns/1ps

// Free-running clock and power-on reset for the testbench
module clk_gen #(
	parameter realtime PERIOD      = 100ns,
	parameter int      RESET_CYCLES = 2
) (
	output logic clk_sys,
	output logic RESET
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		RESET = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		RESET <= 1'b0;
	end

endmodule

/* dv/cart_loader_chk.sv */
`timescale 1ns/1ps

module cart_loader_chk (
	input logic clk_sys,
	input logic RESET,
	input logic gg_stb,
	input logic rom_wr_req,
	input logic ioctl_wait,
	input logic region_set
);

	int fail_cnt = 0; // Failed assertion count

	// Code strobe is a single-cycle pulse
	a_gg_stb_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		gg_stb |=> !gg_stb)
		else begin
			$error("gg_code strobe high for two cycles");
			fail_cnt++;
		end

	// A new request always comes with the rise of the wait
	a_req_with_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		!$stable(rom_wr_req) |-> (ioctl_wait && !$past(ioctl_wait)))
		else begin
			$error("rom_wr_req toggled without a rising ioctl_wait");
			fail_cnt++;
		end

	a_reset_low: assert property (@(posedge clk_sys)
		RESET |=> (!ioctl_wait && !region_set))
		else begin
			$error("ioctl_wait or region_set high after reset");
			fail_cnt++;
		end

endmodule

bind cart_loader cart_loader_chk i_chk (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.gg_stb     (gg_code[128]),
	.rom_wr_req (rom_wr_req),
	.ioctl_wait (ioctl_wait),
	.region_set (region_set)
);

/* dv/cart_loader_tb.sv */
`timescale 1ns/1ps

module cart_loader_tb;

	// Header, index, quirk and cheat writes plus the plain ROM run
	localparam int N_WRITES = 8 + 12 * 3 + 6 + 12 * 6 + 16;

	logic        clk_sys, RESET;
	logic        ioctl_download, ioctl_wr, rom_wr_ack;
	logic [7:0]  ioctl_index;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_data;
	logic        auto_region_en, region_from_header;
	logic        ioctl_wait, rom_wr_req, region_set, gun_type, gg_reset;
	logic [23:0] rom_addr;
	logic [15:0] rom_wdata;
	logic [24:0] rom_size;
	logic [7:0]  gun_sensor_delay;
	logic [128:0] gg_code;
	cart_loader_pkg::region_prio_e  region_prio;
	cart_loader_pkg::region_e       region_req;
	cart_loader_pkg::cart_quirks_t  quirks;

	logic [39:0] exp_rom[$];  // {word address, swapped data}
	logic        in_cart;
	logic        last_req;
	int          toggles, stb_cnt, rst_cnt;

	clk_gen i_clk (.clk_sys(clk_sys), .RESET(RESET));

	cart_loader i_dut (.*);

	task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
		input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %0h, expected %0h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////
	function automatic logic [2:0] letter_flags(input logic [7:0] c);
		return {c == "J", c == "U", c == "E"};
	endfunction

	// Returns {j, u, e} for one header
	function automatic logic [2:0] flags_ref(input logic [7:0] lo, input logic [7:0] hi,
		input logic [7:0] lo2);
		logic [2:0] f;
		logic [3:0] v;
		f = 3'b000;
		if (|letter_flags(lo)) begin
			f = letter_flags(lo);
		end else if (lo >= "0" && lo <= "9") begin
			v = 4'(lo - "0");
			f = {v[0], v[2], v[3]};
		end else if (lo >= "A" && lo <= "F") begin
			v = 4'(lo - "A" + 10);
			f = {v[0], v[2], v[3]};
		end
		return f | letter_flags(hi) | letter_flags(lo2);
	endfunction

	function automatic logic [1:0] region_ref(input logic [1:0] prio, input logic [2:0] f);
		logic [1:0] o[3];
		logic [1:0] r;
		case (prio)
			2'd0: o = '{2'd1, 2'd2, 2'd0};
			2'd1: o = '{2'd2, 2'd1, 2'd0};
			2'd2: o = '{2'd1, 2'd0, 2'd2};
			default: o = '{2'd0, 2'd1, 2'd2};
		endcase
		r = o[0];  // Head of the order when nothing is flagged
		for (int i = 2; i >= 0; i--) begin
			if ((o[i] == 2'd0 && f[2]) || (o[i] == 2'd1 && f[1]) || (o[i] == 2'd2 && f[0]))
				r = o[i];
		end
		return r;
	endfunction

	// {quirk flags, gun type, gun delay}
	function automatic logic [16:0] quirk_ref(input logic [63:0] s);
		logic [7:0] q;
		logic       t;
		logic [7:0] d;
		q = 8'h00;
		t = 1'b0;
		d = 8'd44;
		if (s == "T-081276") q = 8'b1000_0000;
		if (s == "MK-1215 ") q = 8'b0100_0000;
		if (s == "T-89016 ") q = 8'b0010_0000;
		if (s == "T-113016") q = 8'b0001_0000;
		if (s == "T-574023") q = 8'b0000_1000;
		if (s == "MK-1229 ") q = 8'b0000_0100;
		if (s == "T-35036 ") q = 8'b0000_0010;
		if (s == "T-68???-") q = 8'b0000_0001;
		if (s == "MK-1533 ") d = 8'd100;
		if (s == "T-081156") d = 8'd126;
		if (s == "T-95096-") begin
			t = 1'b1;
			d = 8'd52;
		end
		return {q, t, d};
	endfunction

	function automatic logic [127:0] code_ref(input logic [15:0] h[8]);
		return {h[1], h[0], h[3], h[2], h[5], h[4], h[7], h[6]};
	endfunction

	function automatic logic [7:0] rand_char();
		logic [7:0] pool[4];
		pool = '{"J", "U", "E", "X"};
		case ($urandom_range(0, 3))
			0: return pool[$urandom_range(0, 3)];
			1: return 8'("0" + $urandom_range(0, 9));
			2: return 8'("A" + $urandom_range(0, 5));
			default: return 8'("a" + $urandom_range(0, 25));
		endcase
	endfunction

	//////////////////////////////
	// Host side
	//////////////////////////////
	task automatic host_write(input logic [24:0] a, input logic [15:0] d);
		if (in_cart)
			exp_rom.push_back({a[24:1], d[7:0], d[15:8]});
		ioctl_addr <= a;
		ioctl_data <= d;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		repeat (3) @(posedge clk_sys);
		while (ioctl_wait) @(posedge clk_sys);
	endtask

	task automatic start_download(input logic [7:0] idx);
		ioctl_index    <= idx;
		ioctl_download <= 1'b1;
		in_cart = (idx != 8'hFF);
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic end_download();
		ioctl_download <= 1'b0;
		repeat (4) @(posedge clk_sys);
		if (in_cart)
			check_value(rom_size, ioctl_addr, "rom_size");
		in_cart = 1'b0;
	endtask

	// Memory model with random acknowledge latency
	always @(posedge clk_sys) begin
		logic [39:0] e;
		if (!RESET && rom_wr_req !== last_req) begin
			last_req = rom_wr_req;
			toggles++;
			if (exp_rom.size() == 0) begin
				$display("Unexpected ROM write request at %0t", $time);
				$display("Simulation failed");
				$fatal(1);
			end
			e = exp_rom.pop_front();
			check_value({rom_addr, rom_wdata}, e, "ROM address and data");
			repeat ($urandom_range(0, 5)) @(posedge clk_sys);
			rom_wr_ack <= rom_wr_req;
		end
	end

	always @(posedge clk_sys) begin
		if (!RESET) begin
			if (gg_code[128])
				stb_cnt++;
			if (gg_reset)
				rst_cnt++;
		end
	end

	always @(posedge clk_sys) begin
		if (i_dut.i_chk.fail_cnt != 0) begin
			$display("A bound assertion failed before %0t", $time);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	initial begin
		#(N_WRITES * 10 * 100ns * 2);
		$display("Timeout: the run did not finish in time");
		$display("Simulation failed");
		$fatal(1);
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial begin
		logic [7:0]  lo, hi, lo2, idx;
		logic [2:0]  f;
		logic [1:0]  prev_req;
		logic [63:0] serials[12];
		logic [15:0] h[8];
		int          t0;

		void'($urandom(6492));
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_data = '0;
		rom_wr_ack = 1'b0;
		auto_region_en = 1'b1;
		region_from_header = 1'b1;
		region_prio = cart_loader_pkg::PRIO_US_EU_JP;
		in_cart = 1'b0;
		last_req = 1'b0;
		toggles = 0;
		stb_cnt = 0;
		rst_cnt = 0;

		do @(posedge clk_sys); while (RESET);
		check_value({ioctl_wait, rom_wr_req, region_set, gg_reset, gg_code[128]}, 0, "reset levels");
		check_value(region_req, 2'd0, "reset region_req");
		check_value({quirks, gun_type, gun_sensor_delay}, {9'h000, 8'd44}, "reset quirks");

		start_download(8'h00);  // Plain ROM image
		for (int i = 0; i < 8; i++)
			host_write(25'h1000 + 2 * i, 16'($urandom));
		end_download();

		for (int p = 0; p < 4; p++) begin
			region_prio <= cart_loader_pkg::region_prio_e'(p);
			for (int n = 0; n < 3; n++) begin
				lo = rand_char();
				hi = rand_char();
				lo2 = rand_char();
				f = flags_ref(lo, hi, lo2);
				start_download(8'h00);
				host_write(25'h1F0, {hi, lo});
				host_write(25'h1F2, {8'h20, lo2});
				host_write(25'h200, 16'h0000);
				check_value(region_req, region_ref(2'(p), f), "header region_req");
				check_value(region_set, 1'b1, "header region_set");
				end_download();
				check_value(region_set, 1'b0, "region_set after download");
			end
		end

		region_from_header <= 1'b0;
		for (int n = 0; n < 5; n++) begin
			idx = (n == 0) ? 8'h00 : (n == 1) ? 8'h41 : (n == 2) ? 8'h80 : (n == 3) ? 8'hC3 : 8'h07;
			start_download(idx);
			host_write(25'h200, 16'h0000);
			check_value(region_req, idx[7:6], "index region_req");
			check_value(region_set, idx != 8'h00, "index region_set");
			end_download();
		end
		auto_region_en <= 1'b0;  // Region outputs must hold
		prev_req = idx[7:6];
		start_download(8'h41);
		host_write(25'h200, 16'h0000);
		check_value({region_req, region_set}, {prev_req, 1'b0}, "region with auto off");
		end_download();

		serials = '{"T-081276", "MK-1215 ", "T-113016", "T-89016 ", "T-574023", "MK-1229 ",
			"T-35036 ", "T-68???-", "MK-1533 ", "T-95096-", "T-081156", "T-00000 "};
		for (int n = 0; n < 12; n++) begin
			start_download(8'h00);
			check_value(quirks, 8'h00, "quirks after start");
			host_write(25'h182, {serials[n][63:56], 8'h00});
			host_write(25'h184, {serials[n][47:40], serials[n][55:48]});
			host_write(25'h186, {serials[n][31:24], serials[n][39:32]});
			host_write(25'h188, {serials[n][15:8], serials[n][23:16]});
			host_write(25'h18A, {8'h00, serials[n][7:0]});
			host_write(25'h18C, 16'h0000);
			check_value({quirks, gun_type, gun_sensor_delay}, quirk_ref(serials[n]), "quirks");
			end_download();
		end

		t0 = toggles;
		start_download(8'hFF);
		for (int c = 0; c < 2; c++) begin
			for (int k = 0; k < 8; k++) begin
				h[k] = 16'($urandom);
				host_write(25'(16 * c + 2 * k), h[k]);
			end
			check_value(gg_code[127:0], code_ref(h), "gg_code fields");
			check_value(stb_cnt, c + 1, "gg_code strobe count");
		end
		end_download();
		check_value(rst_cnt, 1, "gg_reset pulse count");
		check_value(toggles, t0, "ROM toggles in code download");
		check_value(exp_rom.size(), 0, "pending ROM writes");

		if (i_dut.i_chk.fail_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* cart_loader.f */
hdl/cart_loader_pkg.sv
hdl/ioctl_if.sv
hdl/download_decoder.sv
hdl/header_scanner.sv
hdl/region_select.sv
hdl/rom_write_sequencer.sv
hdl/cheat_code_loader.sv
hdl/cart_loader.sv
dv/clk_gen.sv
dv/cart_loader_chk.sv
dv/cart_loader_tb.sv

/* Bender.yml */
package:
  name: cart_loader

sources:
  - hdl/cart_loader_pkg.sv
  - hdl/ioctl_if.sv
  - hdl/download_decoder.sv
  - hdl/header_scanner.sv
  - hdl/region_select.sv
  - hdl/rom_write_sequencer.sv
  - hdl/cheat_code_loader.sv
  - hdl/cart_loader.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/cart_loader_chk.sv
      - dv/cart_loader_tb.sv
